//--- logic/core_pkg.sv
`default_nettype none

package core_pkg;

    // ----------------------------------------------------------
    // Widths and reset constants
    // ----------------------------------------------------------
    localparam int unsigned XLEN      = 32;
    localparam int unsigned REG_IDX_W = 5;
    localparam int unsigned SHAMT_W   = 5;

    // Stack and global pointer after reset
    localparam logic [XLEN-1:0] RESET_SP = 32'h0000_3ffc;
    localparam logic [XLEN-1:0] RESET_GP = 32'h0000_1800;

    // Major opcode field, inst[6:2]
    localparam logic [4:0] OPC_LOAD   = 5'b00000;
    localparam logic [4:0] OPC_OPIMM  = 5'b00100;
    localparam logic [4:0] OPC_AUIPC  = 5'b00101;
    localparam logic [4:0] OPC_STORE  = 5'b01000;
    localparam logic [4:0] OPC_OP     = 5'b01100;
    localparam logic [4:0] OPC_LUI    = 5'b01101;
    localparam logic [4:0] OPC_BRANCH = 5'b11000;
    localparam logic [4:0] OPC_JALR   = 5'b11001;
    localparam logic [4:0] OPC_JAL    = 5'b11011;

    // ----------------------------------------------------------
    // Enumerations
    // ----------------------------------------------------------
    // NONE passes operand a
    typedef enum logic [3:0] {
        NONE, ADD, SUB, SLL, SRL, SRA,
        SLT, SLTU, XOR, OR, AND
    } alu_op_t;

    typedef enum logic [1:0] {BYTE, HALF, WORD} mem_size_t;

    typedef enum logic [1:0] {RESET, FETCH_WB, EXEC, MEM} state_t;

    // Operand sources
    typedef enum logic [1:0] {A_RS1, A_PC, A_ZERO} a_sel_t;
    typedef enum logic [1:0] {B_RS2, B_IMM, B_FOUR} b_sel_t;

    // ----------------------------------------------------------
    // Structs
    // ----------------------------------------------------------
    typedef struct packed {
        alu_op_t               alu_op;
        a_sel_t                a_sel;
        b_sel_t                b_sel;
        logic [XLEN-1:0]       imm;
        logic [REG_IDX_W-1:0]  rd;
        logic                  rd_write;
        logic                  is_load;
        logic                  is_store;
        logic                  is_branch;
        logic                  is_jal;
        logic                  is_jalr;
        mem_size_t             mem_size;
        logic                  load_signed;
    } dec_ctrl_t;

    // Data request, addr is word aligned
    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
        logic            rd;
        logic [3:0]      wr;
    } dmem_req_t;

    // Load formatting held across MEM
    typedef struct packed {
        logic [1:0] offset;
        mem_size_t  size;
        logic       sign;
    } load_ctl_t;

endpackage

`default_nettype wire

//--- logic/rv_alu.sv
`default_nettype none

module rv_alu
(
    input  core_pkg::alu_op_t         op_i,
    input  logic [core_pkg::XLEN-1:0] a_i,
    input  logic [core_pkg::XLEN-1:0] b_i,
    output logic [core_pkg::XLEN-1:0] result_o
);
    import core_pkg::*;

    logic [SHAMT_W-1:0] shamt_w;
    logic               lt_w;
    logic               ltu_w;

    // Shift amount from low bits of b
    assign shamt_w = b_i[SHAMT_W-1:0];

    // Comparisons
    assign lt_w  = $signed(a_i) < $signed(b_i);
    assign ltu_w = a_i < b_i;

    always_comb
    begin
        case (op_i)
            ADD:     result_o = a_i + b_i;
            SUB:     result_o = a_i - b_i;
            SLL:     result_o = a_i << shamt_w;
            SRL:     result_o = a_i >> shamt_w;
            SRA:     result_o = $signed(a_i) >>> shamt_w;
            SLT:     result_o = {{(XLEN-1){1'b0}}, lt_w};
            SLTU:    result_o = {{(XLEN-1){1'b0}}, ltu_w};
            XOR:     result_o = a_i ^ b_i;
            OR:      result_o = a_i | b_i;
            AND:     result_o = a_i & b_i;
            // Pass a, used for load results
            default: result_o = a_i;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/rv_branch.sv
`default_nettype none

module rv_branch
(
    input  core_pkg::dec_ctrl_t       ctrl_i,
    input  logic [2:0]                inst_func3_i,
    input  logic [core_pkg::XLEN-1:0] pc_i,
    input  logic [core_pkg::XLEN-1:0] rs1_val_i,
    input  logic [core_pkg::XLEN-1:0] rs2_val_i,
    output logic                      taken_o,
    output logic [core_pkg::XLEN-1:0] target_o
);
    import core_pkg::*;

    logic            cond_w;
    logic [XLEN-1:0] jalr_sum_w;

    // Conditional branch compare
    always_comb
    begin
        case (inst_func3_i)
            3'b000:  cond_w = (rs1_val_i == rs2_val_i);
            3'b001:  cond_w = (rs1_val_i != rs2_val_i);
            3'b100:  cond_w = $signed(rs1_val_i) < $signed(rs2_val_i);
            3'b101:  cond_w = $signed(rs1_val_i) >= $signed(rs2_val_i);
            3'b110:  cond_w = rs1_val_i < rs2_val_i;
            3'b111:  cond_w = rs1_val_i >= rs2_val_i;
            // Reserved encodings never branch
            default: cond_w = 1'b0;
        endcase
    end

    assign taken_o = ctrl_i.is_jal | ctrl_i.is_jalr | (ctrl_i.is_branch & cond_w);

    // JALR clears bit 0 of the sum
    assign jalr_sum_w = rs1_val_i + ctrl_i.imm;

    assign target_o = ctrl_i.is_jalr ? {jalr_sum_w[XLEN-1:1], 1'b0}
                                     : pc_i + ctrl_i.imm;

endmodule

`default_nettype wire

//--- logic/rv_core.sv
`default_nettype none

module rv_core
(
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic [core_pkg::XLEN-1:0] reset_vector_i,
    // Instruction port
    output logic                      mem_i_rd_o,
    output logic [core_pkg::XLEN-1:0] mem_i_pc_o,
    input  logic                      mem_i_accept_i,
    input  logic                      mem_i_valid_i,
    input  logic [core_pkg::XLEN-1:0] mem_i_inst_i,
    // Data port
    output core_pkg::dmem_req_t       mem_d_req_o,
    input  logic                      mem_d_accept_i,
    input  logic                      mem_d_ack_i,
    input  logic [core_pkg::XLEN-1:0] mem_d_data_rd_i
);
    import core_pkg::*;

    state_t               state_q;
    state_t               state_d;
    dec_ctrl_t            ctrl_w;
    logic [XLEN-1:0]      rs1_val_w;
    logic [XLEN-1:0]      rs2_val_w;
    logic [XLEN-1:0]      op_a_w;
    logic [XLEN-1:0]      op_b_w;
    logic                 taken_w;
    logic [XLEN-1:0]      target_w;
    logic [XLEN-1:0]      load_val_w;
    logic [XLEN-1:0]      alu_result_w;
    logic                 exec_w;
    logic                 mem_done_w;
    logic                 rd_en_w;
    logic [XLEN-1:0]      pc_q;
    alu_op_t              alu_op_q;
    logic [XLEN-1:0]      alu_a_q;
    logic [XLEN-1:0]      alu_b_q;
    logic [REG_IDX_W-1:0] rd_q;
    logic                 rd_wr_q;

    // Instruction word present in EXEC
    assign exec_w     = (state_q == EXEC) && mem_i_valid_i;
    assign mem_done_w = (state_q == MEM) && mem_d_ack_i;
    // No writeback to x0
    assign rd_en_w    = ctrl_w.rd_write && (ctrl_w.rd != '0);

    // ----------------------------------------------------------
    // State machine
    // ----------------------------------------------------------
    always_comb
    begin
        state_d = state_q;
        case (state_q)
            RESET:    state_d = FETCH_WB;
            // Back-pressure holds the fetch
            FETCH_WB: state_d = mem_i_accept_i ? EXEC : FETCH_WB;
            EXEC:
            begin
                if (mem_i_valid_i)
                    state_d = (ctrl_w.is_load || ctrl_w.is_store) ? MEM : FETCH_WB;
            end
            default:  state_d = mem_d_ack_i ? FETCH_WB : MEM;
        endcase
    end

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            state_q <= RESET;
        else
            state_q <= state_d;
    end

    // PC, boot vector taken in RESET
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            pc_q <= '0;
        else if (state_q == RESET)
            pc_q <= reset_vector_i;
        else if (exec_w)
            pc_q <= taken_w ? target_w : pc_q + XLEN'(4);
    end

    assign mem_i_rd_o = (state_q == FETCH_WB);
    assign mem_i_pc_o = pc_q;

    // ----------------------------------------------------------
    // Operand registers
    // ----------------------------------------------------------
    always_comb
    begin
        case (ctrl_w.a_sel)
            A_PC:    op_a_w = pc_q;
            A_ZERO:  op_a_w = '0;
            default: op_a_w = rs1_val_w;
        endcase
        case (ctrl_w.b_sel)
            B_IMM:   op_b_w = ctrl_w.imm;
            B_FOUR:  op_b_w = XLEN'(4);
            default: op_b_w = rs2_val_w;
        endcase
    end

    // Load value replaces operand a
    always_ff @(posedge clk_i)
    begin
        if (mem_done_w)
        begin
            alu_a_q <= load_val_w;
            alu_b_q <= '0;
        end
        else if (exec_w)
        begin
            alu_a_q <= op_a_w;
            alu_b_q <= op_b_w;
        end
    end

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            alu_op_q <= NONE;
            rd_q     <= '0;
            rd_wr_q  <= 1'b0;
        end
        else if (mem_done_w)
            alu_op_q <= NONE;
        else if (exec_w)
        begin
            alu_op_q <= ctrl_w.alu_op;
            rd_q     <= rd_en_w ? ctrl_w.rd : '0;
            rd_wr_q  <= rd_en_w;
        end
        // Writeback only in first FETCH_WB cycle
        else if (state_q == FETCH_WB)
            rd_wr_q <= 1'b0;
    end

    // ----------------------------------------------------------
    // Instances
    // ----------------------------------------------------------
    rv_decoder u_decoder
    (
        .inst_i (mem_i_inst_i),
        .ctrl_o (ctrl_w)
    );

    rv_regfile u_regfile
    (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .rs1_idx_i (mem_i_inst_i[19:15]),
        .rs2_idx_i (mem_i_inst_i[24:20]),
        .rs1_val_o (rs1_val_w),
        .rs2_val_o (rs2_val_w),
        .wr_en_i   (rd_wr_q && (state_q == FETCH_WB)),
        .wr_idx_i  (rd_q),
        .wr_val_i  (alu_result_w)
    );

    rv_alu u_alu
    (
        .op_i     (alu_op_q),
        .a_i      (alu_a_q),
        .b_i      (alu_b_q),
        .result_o (alu_result_w)
    );

    rv_branch u_branch
    (
        .ctrl_i       (ctrl_w),
        .inst_func3_i (mem_i_inst_i[14:12]),
        .pc_i         (pc_q),
        .rs1_val_i    (rs1_val_w),
        .rs2_val_i    (rs2_val_w),
        .taken_o      (taken_w),
        .target_o     (target_w)
    );

    rv_lsu u_lsu
    (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .exec_i        (exec_w),
        .ctrl_i        (ctrl_w),
        .rs1_val_i     (rs1_val_w),
        .rs2_val_i     (rs2_val_w),
        .mem_accept_i  (mem_d_accept_i),
        .mem_data_rd_i (mem_d_data_rd_i),
        .req_o         (mem_d_req_o),
        .load_val_o    (load_val_w)
    );

endmodule

`default_nettype wire

//--- logic/rv_decoder.sv
`default_nettype none

module rv_decoder
(
    input  logic [core_pkg::XLEN-1:0] inst_i,
    output core_pkg::dec_ctrl_t       ctrl_o
);
    import core_pkg::*;

    logic [4:0]      opcode_w;
    logic [2:0]      func3_w;
    logic [XLEN-1:0] imm_i_w;
    logic [XLEN-1:0] imm_s_w;
    logic [XLEN-1:0] imm_b_w;
    logic [XLEN-1:0] imm_u_w;
    logic [XLEN-1:0] imm_j_w;
    alu_op_t         arith_op_w;

    assign opcode_w = inst_i[6:2];
    assign func3_w  = inst_i[14:12];

    // ----------------------------------------------------------
    // Immediate formats
    // ----------------------------------------------------------
    assign imm_i_w = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s_w = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b_w = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                      inst_i[11:8], 1'b0};
    assign imm_u_w = {inst_i[31:12], 12'b0};
    assign imm_j_w = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                      inst_i[30:21], 1'b0};

    // ALU op for OP and OP-IMM
    always_comb
    begin
        case (func3_w)
            // Bit 30 selects SUB on register form only
            3'b000:  arith_op_w = (opcode_w == OPC_OP && inst_i[30]) ? SUB : ADD;
            3'b001:  arith_op_w = SLL;
            3'b010:  arith_op_w = SLT;
            3'b011:  arith_op_w = SLTU;
            3'b100:  arith_op_w = XOR;
            3'b101:  arith_op_w = inst_i[30] ? SRA : SRL;
            3'b110:  arith_op_w = OR;
            default: arith_op_w = AND;
        endcase
    end

    // ----------------------------------------------------------
    // Control word
    // ----------------------------------------------------------
    always_comb
    begin
        // Unknown opcode and FENCE fall through as no-op
        ctrl_o    = '0;
        ctrl_o.rd = inst_i[11:7];

        case (opcode_w)
            OPC_OP:
            begin
                ctrl_o.alu_op   = arith_op_w;
                ctrl_o.rd_write = 1'b1;
            end
            OPC_OPIMM:
            begin
                ctrl_o.alu_op   = arith_op_w;
                ctrl_o.b_sel    = B_IMM;
                ctrl_o.imm      = imm_i_w;
                ctrl_o.rd_write = 1'b1;
            end
            OPC_LUI, OPC_AUIPC:
            begin
                ctrl_o.alu_op   = ADD;
                ctrl_o.a_sel    = (opcode_w == OPC_LUI) ? A_ZERO : A_PC;
                ctrl_o.b_sel    = B_IMM;
                ctrl_o.imm      = imm_u_w;
                ctrl_o.rd_write = 1'b1;
            end
            // Link value is PC plus four
            OPC_JAL, OPC_JALR:
            begin
                ctrl_o.alu_op   = ADD;
                ctrl_o.a_sel    = A_PC;
                ctrl_o.b_sel    = B_FOUR;
                ctrl_o.imm      = (opcode_w == OPC_JAL) ? imm_j_w : imm_i_w;
                ctrl_o.is_jal   = (opcode_w == OPC_JAL);
                ctrl_o.is_jalr  = (opcode_w == OPC_JALR);
                ctrl_o.rd_write = 1'b1;
            end
            OPC_BRANCH:
            begin
                ctrl_o.imm       = imm_b_w;
                ctrl_o.is_branch = 1'b1;
            end
            OPC_LOAD:
            begin
                ctrl_o.imm         = imm_i_w;
                ctrl_o.is_load     = 1'b1;
                ctrl_o.rd_write    = 1'b1;
                ctrl_o.mem_size    = mem_size_t'(func3_w[1:0]);
                ctrl_o.load_signed = ~func3_w[2];
            end
            OPC_STORE:
            begin
                ctrl_o.imm      = imm_s_w;
                ctrl_o.is_store = 1'b1;
                ctrl_o.mem_size = mem_size_t'(func3_w[1:0]);
            end
            default:
            begin
                ctrl_o.rd_write = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- logic/rv_lsu.sv
`default_nettype none

module rv_lsu
(
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      exec_i,
    input  core_pkg::dec_ctrl_t       ctrl_i,
    input  logic [core_pkg::XLEN-1:0] rs1_val_i,
    input  logic [core_pkg::XLEN-1:0] rs2_val_i,
    input  logic                      mem_accept_i,
    input  logic [core_pkg::XLEN-1:0] mem_data_rd_i,
    output core_pkg::dmem_req_t       req_o,
    output logic [core_pkg::XLEN-1:0] load_val_o
);
    import core_pkg::*;

    logic [XLEN-1:0] addr_w;
    logic [XLEN-1:0] wdata_w;
    logic [3:0]      strb_w;
    logic [XLEN-1:0] addr_q;
    logic [XLEN-1:0] wdata_q;
    logic            rd_q;
    logic [3:0]      wr_q;
    load_ctl_t       load_q;
    logic [XLEN-1:0] shifted_w;

    // Effective address
    assign addr_w = rs1_val_i + ctrl_i.imm;

    // ----------------------------------------------------------
    // Store lanes
    // ----------------------------------------------------------
    always_comb
    begin
        case (ctrl_i.mem_size)
            BYTE:
            begin
                wdata_w = {4{rs2_val_i[7:0]}};
                strb_w  = 4'b0001 << addr_w[1:0];
            end
            HALF:
            begin
                wdata_w = {2{rs2_val_i[15:0]}};
                strb_w  = addr_w[1] ? 4'b1100 : 4'b0011;
            end
            default:
            begin
                wdata_w = rs2_val_i;
                strb_w  = 4'b1111;
            end
        endcase
    end

    // Request payload
    always_ff @(posedge clk_i)
    begin
        if (exec_i)
        begin
            addr_q  <= {addr_w[XLEN-1:2], 2'b00};
            wdata_q <= wdata_w;
        end
    end

    // Strobes held until accepted
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            rd_q   <= 1'b0;
            wr_q   <= 4'b0000;
            load_q <= '0;
        end
        else if (exec_i)
        begin
            rd_q          <= ctrl_i.is_load;
            wr_q          <= ctrl_i.is_store ? strb_w : 4'b0000;
            load_q.offset <= addr_w[1:0];
            load_q.size   <= ctrl_i.mem_size;
            load_q.sign   <= ctrl_i.load_signed;
        end
        else if (mem_accept_i)
        begin
            rd_q <= 1'b0;
            wr_q <= 4'b0000;
        end
    end

    assign req_o = '{addr: addr_q, wdata: wdata_q, rd: rd_q, wr: wr_q};

    // ----------------------------------------------------------
    // Load alignment
    // ----------------------------------------------------------
    // Selected lane moved down to bit 0
    assign shifted_w = mem_data_rd_i >> {load_q.offset, 3'b000};

    always_comb
    begin
        case (load_q.size)
            BYTE:    load_val_o = {{24{load_q.sign & shifted_w[7]}}, shifted_w[7:0]};
            HALF:    load_val_o = {{16{load_q.sign & shifted_w[15]}}, shifted_w[15:0]};
            default: load_val_o = mem_data_rd_i;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/rv_regfile.sv
`default_nettype none

module rv_regfile
(
    input  logic                           clk_i,
    input  logic                           rst_i,
    input  logic [core_pkg::REG_IDX_W-1:0] rs1_idx_i,
    input  logic [core_pkg::REG_IDX_W-1:0] rs2_idx_i,
    output logic [core_pkg::XLEN-1:0]      rs1_val_o,
    output logic [core_pkg::XLEN-1:0]      rs2_val_o,
    input  logic                           wr_en_i,
    input  logic [core_pkg::REG_IDX_W-1:0] wr_idx_i,
    input  logic [core_pkg::XLEN-1:0]      wr_val_i
);
    import core_pkg::*;

    logic [XLEN-1:0] regs_q [2**REG_IDX_W];

    // Write port, x0 is never addressed by the core
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            for (int i = 0; i < 2**REG_IDX_W; i++)
                regs_q[i] <= '0;
            // SP and GP start at the memory map values
            regs_q[2] <= RESET_SP;
            regs_q[3] <= RESET_GP;
        end
        else if (wr_en_i)
            regs_q[wr_idx_i] <= wr_val_i;
    end

    // Asynchronous read
    assign rs1_val_o = regs_q[rs1_idx_i];
    assign rs2_val_o = regs_q[rs2_idx_i];

endmodule

`default_nettype wire

//--- sources.f
logic/core_pkg.sv
logic/rv_decoder.sv
logic/rv_regfile.sv
logic/rv_alu.sv
logic/rv_branch.sv
logic/rv_lsu.sv
logic/rv_core.sv
test/rv_core_sva.sv
test/tb_rv_core.sv

//--- test/program_input.hex
// Word image read into the testbench array by word index
// @00 program words, @40 initial data at GP, @48 store count, @49 records of addr strobe data
@00
// ALU register and immediate results
06400293 ff900313 006283b3 40530433
40135493 0062b533 005325b3 00a59633
fe712e23 fe812c23 fe912a23 fec12823
// LUI, logic ops, AUIPC
12345737 0ff74793 0067f833 00885913
00001897 011949b3 ff012623 ff312423
// Branch markers in x20, then JAL link
00628463 001a6a13 00629463 002a6a13
00534463 004a6a13 0062f463 008a6a13
00800aef 010a6a13 ff412223 ff512023
// JALR to 0x90 skips two stray stores
09100b13 000b0be7 fe012e23 fe012e23
// Loads from GP and their word stores
fd712e23 00318c03 0021cc83 00619d03
0041dd83 0001ae03 fd812c23 fd912a23
fda12823 fdb12623 fdc12423 01c188a3
// Byte and half stores, then the final self loop
01c189a3 01a19b23 01b19a23 00718823
0000006f
@40
80f17f25 80017ffe
@48
00000013
// addr     strobe   masked data
00003ff8 0000000f 0000005d
00003ff4 0000000f ffffff95
00003ff0 0000000f fffffffc
00003fec 0000000f 00000002
00003fe8 0000000f 123450f9
00003fe4 0000000f 00122410
00003fe0 0000000f 00000009
00003fdc 0000000f 00000074
00003fd8 0000000f 00000088
00003fd4 0000000f ffffff80
00003fd0 0000000f 000000f1
00003fcc 0000000f ffff8001
00003fc8 0000000f 00007ffe
00003fc4 0000000f 80f17f25
00001810 00000002 00002500
00001810 00000008 25000000
00001814 0000000c 80010000
00001814 00000003 00007ffe
00001810 00000001 0000005d

//--- test/rv_core_sva.sv
`default_nettype none

module rv_core_sva
(
    input logic                      clk_i,
    input logic                      rst_i,
    input logic                      fetch_rd_i,
    input logic [core_pkg::XLEN-1:0] fetch_pc_i,
    input core_pkg::dmem_req_t       dreq_i,
    input logic                      daccept_i
);
    import core_pkg::*;

    // Count of failed attempts
    int unsigned fail_count = 0;

    // ------------------------------------------------------------
    // Port protocol
    // ------------------------------------------------------------
    // Quiet ports in reset
    a_reset_quiet: assert property (@(posedge clk_i)
        rst_i |-> !fetch_rd_i && !dreq_i.rd && (dreq_i.wr == 4'b0000))
        else
        begin
            fail_count++;
            $error("request raised during reset");
        end

    // Read and write exclusive
    a_rd_wr_excl: assert property (@(posedge clk_i) disable iff (rst_i)
        !(dreq_i.rd && (dreq_i.wr != 4'b0000)))
        else
        begin
            fail_count++;
            $error("data read and write raised together");
        end

    // Held until accepted
    a_req_stable: assert property (@(posedge clk_i) disable iff (rst_i)
        (dreq_i.rd || (dreq_i.wr != 4'b0000)) && !daccept_i |=> $stable(dreq_i))
        else
        begin
            fail_count++;
            $error("data request changed before accept");
        end

    a_pc_aligned: assert property (@(posedge clk_i) disable iff (rst_i)
        fetch_rd_i |-> (fetch_pc_i[1:0] == 2'b00))
        else
        begin
            fail_count++;
            $error("fetch address not word aligned");
        end

endmodule

bind rv_core rv_core_sva u_sva
(
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .fetch_rd_i (mem_i_rd_o),
    .fetch_pc_i (mem_i_pc_o),
    .dreq_i     (mem_d_req_o),
    .daccept_i  (mem_d_accept_i)
);

`default_nettype wire

//--- test/tb_rv_core.sv
`default_nettype none

module tb_rv_core;
    import core_pkg::*;

    // Image layout in word indices
    localparam int DATA_IDX      = 'h40;
    localparam int COUNT_IDX     = 'h48;
    localparam int REC_IDX       = 'h49;
    localparam int TRACE_TIMEOUT = 4000;
    localparam int FETCH_TIMEOUT = 50;
    // Boot vector outside the program image
    localparam logic [XLEN-1:0] ALT_VECTOR = 32'h0000_0800;

    logic            clk = 1'b0;
    logic            rst = 1'b0;
    logic [XLEN-1:0] reset_vector = '0;
    logic            mem_i_rd;
    logic [XLEN-1:0] mem_i_pc;
    logic            mem_i_accept = 1'b0;
    logic            mem_i_valid = 1'b0;
    logic [XLEN-1:0] mem_i_inst = '0;
    dmem_req_t       mem_d_req;
    logic            mem_d_accept = 1'b0;
    logic            mem_d_ack = 1'b0;
    logic [XLEN-1:0] mem_d_data_rd = '0;

    logic [XLEN-1:0] image_q [0:255];
    logic [XLEN-1:0] dmem_q [logic [XLEN-3:0]];
    int              record_count;
    int              store_idx;
    int              error_count = 0;
    bit              random_delays;
    bit              first_fetch_seen;
    // Port model state
    logic            ifetch_busy = 1'b0;
    logic [XLEN-1:0] ifetch_pc;
    int unsigned     ival_wait;
    int unsigned     iacc_wait;
    logic            dmem_busy = 1'b0;
    logic [XLEN-1:0] dmem_rdata_q;
    int unsigned     dack_wait;
    int unsigned     dacc_wait;

    rv_core rv_core_inst
    (
        .clk_i           (clk),
        .rst_i           (rst),
        .reset_vector_i  (reset_vector),
        .mem_i_rd_o      (mem_i_rd),
        .mem_i_pc_o      (mem_i_pc),
        .mem_i_accept_i  (mem_i_accept),
        .mem_i_valid_i   (mem_i_valid),
        .mem_i_inst_i    (mem_i_inst),
        .mem_d_req_o     (mem_d_req),
        .mem_d_accept_i  (mem_d_accept),
        .mem_d_ack_i     (mem_d_ack),
        .mem_d_data_rd_i (mem_d_data_rd)
    );

    initial
    begin
        forever #10 clk = ~clk;
    end

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    task automatic report_failure();
        $display("Checks failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string name, input logic [XLEN-1:0] got,
                                   input logic [XLEN-1:0] exp);
        error_count++;
        $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        report_failure();
    endtask

    function automatic int unsigned pick_delay();
        if (random_delays)
            return $urandom_range(3, 0);
        return 0;
    endfunction

    function automatic logic [XLEN-1:0] strobe_mask(input logic [3:0] strb);
        return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    endfunction

    // Unwritten words read back a pattern of their own address
    function automatic logic [XLEN-1:0] read_data_word(input logic [XLEN-1:0] addr);
        if (dmem_q.exists(addr[XLEN-1:2]))
            return dmem_q[addr[XLEN-1:2]];
        return {addr[XLEN-1:2], 2'b00} ^ 32'h5a5a_c3c3;
    endfunction

    function automatic logic [XLEN-1:0] imem_word(input logic [XLEN-1:0] pc);
        if (pc[XLEN-1:8] == '0)
            return image_q[pc[7:2]];
        return 32'h0000_0013;
    endfunction

    task automatic load_data_memory();
        dmem_q.delete();
        dmem_q[RESET_GP[XLEN-1:2]]       = image_q[DATA_IDX];
        dmem_q[RESET_GP[XLEN-1:2] + 'd1] = image_q[DATA_IDX + 1];
    endtask

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------
    task automatic check_fetch_pc(input logic [XLEN-1:0] got);
        if (got !== reset_vector)
            report_mismatch("mem_i_pc_o", got, reset_vector);
    endtask

    // Compare against the next store record
    task automatic check_store(input dmem_req_t got);
        dmem_req_t exp;
        if (store_idx >= record_count)
        begin
            $display("Store to %h arrived after the expected trace ended", got.addr);
            report_failure();
        end
        else
        begin
            exp.addr  = image_q[REC_IDX + 3 * store_idx];
            exp.wr    = image_q[REC_IDX + 3 * store_idx + 1][3:0];
            exp.wdata = image_q[REC_IDX + 3 * store_idx + 2];
            exp.rd    = 1'b0;
            if (got.addr !== exp.addr)
                report_mismatch("mem_d_req_o.addr", got.addr, exp.addr);
            if (got.rd !== exp.rd)
                report_mismatch("mem_d_req_o.rd", XLEN'(got.rd), XLEN'(exp.rd));
            if (got.wr !== exp.wr)
                report_mismatch("mem_d_req_o.wr", XLEN'(got.wr), XLEN'(exp.wr));
            if ((got.wdata & strobe_mask(got.wr)) !== exp.wdata)
                report_mismatch("mem_d_req_o.wdata", got.wdata & strobe_mask(got.wr),
                                exp.wdata);
            store_idx++;
        end
    endtask

    // Watch the bound port assertions
    always @(negedge clk)
    begin
        if (rv_core_inst.u_sva.fail_count != 0)
        begin
            $display("A port protocol assertion on the core failed");
            report_failure();
        end
    end

    // ------------------------------------------------------------
    // Instruction port model
    // ------------------------------------------------------------
    always @(posedge clk)
    begin : imem_model
        int unsigned delay;
        mem_i_valid <= 1'b0;
        if (rst)
        begin
            mem_i_accept <= 1'b0;
            ifetch_busy  <= 1'b0;
            iacc_wait    <= 0;
            first_fetch_seen = 1'b0;
        end
        else if (ifetch_busy)
        begin
            if (ival_wait == 0)
            begin
                mem_i_valid <= 1'b1;
                mem_i_inst  <= imem_word(ifetch_pc);
                ifetch_busy <= 1'b0;
            end
            else
                ival_wait <= ival_wait - 1;
        end
        else if (mem_i_rd && mem_i_accept)
        begin
            if (!first_fetch_seen)
                check_fetch_pc(mem_i_pc);
            first_fetch_seen = 1'b1;
            // Accept delay for the next fetch
            delay = pick_delay();
            iacc_wait    <= delay;
            mem_i_accept <= (delay == 0);
            delay = pick_delay();
            if (delay == 0)
            begin
                mem_i_valid <= 1'b1;
                mem_i_inst  <= imem_word(mem_i_pc);
            end
            else
            begin
                ifetch_busy <= 1'b1;
                ifetch_pc   <= mem_i_pc;
                ival_wait   <= delay - 1;
            end
        end
        else if (mem_i_rd)
        begin
            if (iacc_wait == 0)
                mem_i_accept <= 1'b1;
            else
                iacc_wait <= iacc_wait - 1;
        end
    end

    // ------------------------------------------------------------
    // Data port model
    // ------------------------------------------------------------
    always @(posedge clk)
    begin : dmem_model
        int unsigned     delay;
        logic [XLEN-1:0] word;
        mem_d_ack <= 1'b0;
        if (rst)
        begin
            mem_d_accept <= 1'b0;
            dmem_busy    <= 1'b0;
            dacc_wait    <= 0;
        end
        else if (dmem_busy)
        begin
            if (dack_wait == 0)
            begin
                mem_d_ack     <= 1'b1;
                mem_d_data_rd <= dmem_rdata_q;
                dmem_busy     <= 1'b0;
            end
            else
                dack_wait <= dack_wait - 1;
        end
        else if ((mem_d_req.rd || mem_d_req.wr != 4'b0000) && mem_d_accept)
        begin
            word = read_data_word(mem_d_req.addr);
            if (mem_d_req.wr != 4'b0000)
            begin
                check_store(mem_d_req);
                // Merge the enabled lanes
                for (int b = 0; b < 4; b++)
                    if (mem_d_req.wr[b])
                        word[8*b +: 8] = mem_d_req.wdata[8*b +: 8];
                dmem_q[mem_d_req.addr[XLEN-1:2]] = word;
            end
            delay = pick_delay();
            dacc_wait    <= delay;
            mem_d_accept <= (delay == 0);
            delay = pick_delay();
            if (delay == 0)
            begin
                mem_d_ack     <= 1'b1;
                mem_d_data_rd <= word;
            end
            else
            begin
                dmem_busy    <= 1'b1;
                dmem_rdata_q <= word;
                dack_wait    <= delay - 1;
            end
        end
        else if (mem_d_req.rd || mem_d_req.wr != 4'b0000)
        begin
            if (dacc_wait == 0)
                mem_d_accept <= 1'b1;
            else
                dacc_wait <= dacc_wait - 1;
        end
    end

    // Boot from another vector until the first fetch is taken
    task automatic boot_from_vector(input logic [XLEN-1:0] vector);
        int cycles;
        @(posedge clk);
        rst          <= 1'b1;
        reset_vector <= vector;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        cycles = 0;
        while (!first_fetch_seen && cycles < FETCH_TIMEOUT)
        begin
            @(posedge clk);
            cycles++;
        end
        if (!first_fetch_seen)
        begin
            $display("Timeout: no fetch taken after reset from vector %h", vector);
            report_failure();
        end
    endtask

    // One full pass of the program from reset
    task automatic run_program(input bit with_delays);
        int cycles;
        @(posedge clk);
        rst          <= 1'b1;
        reset_vector <= '0;
        random_delays = with_delays;
        load_data_memory();
        store_idx = 0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        cycles = 0;
        while (store_idx < record_count && cycles < TRACE_TIMEOUT)
        begin
            @(posedge clk);
            cycles++;
        end
        if (store_idx < record_count)
        begin
            $display("Timeout: only %0d of %0d stores seen", store_idx, record_count);
            report_failure();
        end
        // Self loop must stay silent
        repeat (20) @(posedge clk);
    endtask

    initial
    begin
        void'($urandom(32'h7e05));
        $readmemh("test/program_input.hex", image_q);
        record_count = image_q[COUNT_IDX];
        if (record_count <= 0 || record_count > 60)
        begin
            $display("The data file holds no usable store count");
            report_failure();
        end
        boot_from_vector(ALT_VECTOR);
        run_program(1'b0);
        run_program(1'b1);
        if (error_count == 0)
        begin
            $display("All checks passed");
            $finish;
        end
        else
            report_failure();
    end

endmodule

`default_nettype wire
